//--- sim.f
source/mipsIsaPkg.sv
source/pipeCtrlPkg.sv
source/exMemIf.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memStage.sv
source/hazardUnit.sv
source/mipsCore.sv
tb/mipsCore_asserts.sv
tb/mipsCoreTb.sv

//--- source/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  wire         clk_i,
    input  wire         arstN_i,
    input  wire  [31:0] instrD_i,
    input  wire  [31:0] pcPlus4D_i,
    input  wire         validD_i,
    input  wire         stall_i,     // hold ID/EX
    input  wire         flush_i,     // bubble into ID/EX
    input  wire         wbEn_i,
    input  wire  [4:0]  wbAddr_i,
    input  wire  [31:0] wbData_i,
    output logic [4:0]  rsD_o,
    output logic [4:0]  rtD_o,
    output logic        jumpTaken_o,
    output logic [31:0] jumpTarget_o,
    output ctrlT        ctrlE_o,
    output logic [31:0] rsValE_o,
    output logic [31:0] rtValE_o,
    output logic [31:0] immE_o,
    output logic [4:0]  shamtE_o,
    output logic [4:0]  rsE_o,
    output logic [4:0]  rtE_o,
    output logic [4:0]  destE_o,
    output logic [31:0] pcPlus4E_o,
    output logic        validE_o
);

    opcodeE      opcode;
    functE       funct;
    ctrlT        ctrl;
    logic [4:0]  dest;
    logic [31:0] imm;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] regFile [32];
    logic        issue;

    assign opcode = opcodeE'(instrD_i[31:26]);
    assign funct  = functE'(instrD_i[5:0]);
    assign rsD_o  = instrD_i[25:21];
    assign rtD_o  = instrD_i[20:16];
    assign imm    = {{16{instrD_i[15]}}, instrD_i[15:0]};
    assign issue  = validD_i && !flush_i;

    // J resolves here, one bubble
    assign jumpTaken_o  = validD_i && opcode == OP_J;
    assign jumpTarget_o = {pcPlus4D_i[31:28], instrD_i[25:0], 2'b00};

    always_comb begin
        ctrl = '0;              // unknown encodings act as a nop
        dest = rtD_o;
        case (opcode)
            OP_SPECIAL: begin
                dest          = instrD_i[15:11];
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLL:  ctrl.aluOp = ALU_SLL;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_BEQ:  ctrl.branchEq = 1'b1;
            OP_BNE:  ctrl.branchNe = 1'b1;
            default: ctrl = '0;
        endcase
        if (dest == 5'd0) begin
            ctrl.regWrite = 1'b0;   // r0 stays zero, never reaches writeback
        end
    end

    always_ff @(posedge clk_i) begin
        if (wbEn_i && wbAddr_i != 5'd0) begin
            regFile[wbAddr_i] <= wbData_i;
        end
    end

    // same-cycle writeback bypass
    assign rsVal = (rsD_o == 5'd0) ? 32'd0 :
                   (wbEn_i && wbAddr_i == rsD_o) ? wbData_i : regFile[rsD_o];
    assign rtVal = (rtD_o == 5'd0) ? 32'd0 :
                   (wbEn_i && wbAddr_i == rtD_o) ? wbData_i : regFile[rtD_o];

    // ID/EX
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            validE_o <= 1'b0;
            ctrlE_o  <= '0;
        end else if (!stall_i) begin
            validE_o <= issue;
            ctrlE_o  <= issue ? ctrl : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            rsValE_o   <= rsVal;
            rtValE_o   <= rtVal;
            immE_o     <= imm;
            shamtE_o   <= instrD_i[10:6];
            rsE_o      <= rsD_o;
            rtE_o      <= rtD_o;
            destE_o    <= dest;
            pcPlus4E_o <= pcPlus4D_i;
        end else begin
            // held slot would lose a producer leaving WB, so snoop the write
            if (wbEn_i && wbAddr_i == rsE_o) begin
                rsValE_o <= wbData_i;
            end
            if (wbEn_i && wbAddr_i == rtE_o) begin
                rtValE_o <= wbData_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/exMemIf.sv
`timescale 1ns/1ps
`default_nettype none

interface exMemIf
    import pipeCtrlPkg::*;
();

    logic        valid;
    ctrlT        ctrl;
    logic [31:0] aluResult;    // also the data memory address
    logic [31:0] storeData;    // forwarded rt value for SW
    logic [4:0]  destReg;

    modport exStage (
        output valid, ctrl, aluResult, storeData, destReg
    );

    modport memStage (
        input valid, ctrl, aluResult, storeData, destReg
    );

endinterface

`default_nettype wire

//--- source/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  wire         clk_i,
    input  wire         arstN_i,
    input  wire         stall_i,
    input  wire ctrlT   ctrlE_i,
    input  wire  [31:0] rsValE_i,
    input  wire  [31:0] rtValE_i,
    input  wire  [31:0] immE_i,
    input  wire  [4:0]  shamtE_i,
    input  wire  [4:0]  destE_i,
    input  wire  [31:0] pcPlus4E_i,
    input  wire         validE_i,
    input  wire fwdSelE fwdA_i,
    input  wire fwdSelE fwdB_i,
    input  wire  [31:0] wbData_i,
    output logic        branchTaken_o,
    output logic [31:0] branchTarget_o,
    exMemIf.exStage     exMem
);

    logic [31:0] srcA;
    logic [31:0] rtFwd;     // forwarded rt, before the immediate mux
    logic [31:0] srcB;
    logic [31:0] aluResult;

    always_comb begin
        case (fwdA_i)
            FWD_FROM_MEM: srcA = exMem.aluResult;
            FWD_FROM_WB:  srcA = wbData_i;
            default:      srcA = rsValE_i;
        endcase
        case (fwdB_i)
            FWD_FROM_MEM: rtFwd = exMem.aluResult;
            FWD_FROM_WB:  rtFwd = wbData_i;
            default:      rtFwd = rtValE_i;
        endcase
    end

    assign srcB = ctrlE_i.aluSrcImm ? immE_i : rtFwd;

    always_comb begin
        case (ctrlE_i.aluOp)
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_SLT: aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
            ALU_SLL: aluResult = srcB << shamtE_i;
            default: aluResult = srcA + srcB;
        endcase
    end

    // predicted not taken, a hit costs two bubbles
    assign branchTaken_o  = validE_i && ((ctrlE_i.branchEq && srcA == rtFwd) ||
                                         (ctrlE_i.branchNe && srcA != rtFwd));
    assign branchTarget_o = pcPlus4E_i + {immE_i[29:0], 2'b00};

    // EX/MEM
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            exMem.valid <= 1'b0;
            exMem.ctrl  <= '0;
        end else if (!stall_i) begin
            exMem.valid <= validE_i;
            exMem.ctrl  <= ctrlE_i;     // bubbles already carry zero control
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            exMem.aluResult <= aluResult;
            exMem.storeData <= rtFwd;
            exMem.destReg   <= destE_i;
        end
    end

endmodule

`default_nettype wire

//--- source/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  wire         clk_i,
    input  wire         arstN_i,
    input  wire         stall_i,
    input  wire         flush_i,
    input  wire         jumpTaken_i,
    input  wire  [31:0] jumpTarget_i,
    input  wire         branchTaken_i,
    input  wire  [31:0] branchTarget_i,
    output logic [31:0] imemAddr_o,
    input  wire  [31:0] imemRdata_i,
    output logic [31:0] instrD_o,
    output logic [31:0] pcPlus4D_o,
    output logic        validD_o
);

    logic [31:0] pc;
    logic [31:0] pcPlus4;

    assign pcPlus4    = pc + 32'd4;
    assign imemAddr_o = pc;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pc <= resetPc;
        end else if (!stall_i) begin
            if (branchTaken_i) begin
                pc <= branchTarget_i;   // older instruction, so it wins over a jump
            end else if (jumpTaken_i) begin
                pc <= jumpTarget_i;
            end else begin
                pc <= pcPlus4;
            end
        end
    end

    // IF/ID
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            validD_o <= 1'b0;
        end else if (!stall_i) begin
            validD_o <= !flush_i;   // squash the wrong-path fetch
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            instrD_o   <= imemRdata_i;
            pcPlus4D_o <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
    import pipeCtrlPkg::*;
(
    input  wire  [4:0] rsD_i, rtD_i,
    input  wire  [4:0] rsE_i, rtE_i,
    input  wire  [4:0] destE_i,
    input  wire        loadE_i,
    input  wire        regWriteE_i,
    input  wire  [4:0] destM_i,
    input  wire        regWriteM_i,
    input  wire  [4:0] wbAddr_i,
    input  wire        wbEn_i,
    input  wire        branchTaken_i,
    input  wire        jumpTaken_i,
    input  wire        memBusy_i,
    output logic       stallFD_o,
    output logic       flushD_o,
    output logic       flushE_o,
    output fwdSelE     fwdA_o,
    output fwdSelE     fwdB_o
);

    logic loadUse;

    function automatic fwdSelE pickSource(input logic [4:0] src);
        pickSource = FWD_REGFILE;
        if (src != 5'd0 && wbEn_i && wbAddr_i == src) begin
            pickSource = FWD_FROM_WB;
        end
        if (src != 5'd0 && regWriteM_i && destM_i == src) begin
            pickSource = FWD_FROM_MEM;  // younger producer overrides
        end
    endfunction

    always_comb begin
        fwdA_o = pickSource(rsE_i);
        fwdB_o = pickSource(rtE_i);
    end

    // load result is not ready until it reaches WB
    assign loadUse = loadE_i && regWriteE_i && destE_i != 5'd0 &&
                     (destE_i == rsD_i || destE_i == rtD_i);

    assign stallFD_o = loadUse || memBusy_i;
    assign flushD_o  = branchTaken_i || jumpTaken_i;
    assign flushE_o  = branchTaken_i || loadUse;   // stages ignore it while held

endmodule

`default_nettype wire

//--- source/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage (
    input  wire         clk_i,
    input  wire         arstN_i,
    exMemIf.memStage    exMem,
    output logic        dmemReq_o,
    output logic        dmemWe_o,
    output logic [31:0] dmemAddr_o,
    output logic [31:0] dmemWdata_o,
    input  wire         dmemAck_i,
    input  wire  [31:0] dmemRdata_i,
    output logic        memBusy_o,
    output logic        wbEn_o,
    output logic [4:0]  wbAddr_o,
    output logic [31:0] wbData_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE
    } memStateE;

    memStateE    state;
    memStateE    stateNext;
    logic        memOp;
    logic        done;      // instruction leaves MEM this cycle
    logic [31:0] loadData;

    assign memOp = exMem.valid && (exMem.ctrl.memRead || exMem.ctrl.memWrite);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (memOp) begin
                    stateNext = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (dmemAck_i) begin
                    stateNext = WAIT_RELEASE;
                end
            end
            WAIT_RELEASE: begin
                if (!dmemAck_i) begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // EX/MEM is frozen during the access, so these hold while req is up
    assign dmemReq_o   = state == WAIT_ACK;
    assign dmemWe_o    = exMem.ctrl.memWrite;
    assign dmemAddr_o  = exMem.aluResult;
    assign dmemWdata_o = exMem.storeData;

    assign done      = (state == IDLE && !memOp) || (state == WAIT_RELEASE && !dmemAck_i);
    assign memBusy_o = !done;

    always_ff @(posedge clk_i) begin
        if (state == WAIT_ACK && dmemAck_i) begin
            loadData <= dmemRdata_i;
        end
    end

    // MEM/WB, one enable pulse per instruction
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            wbEn_o <= 1'b0;
        end else begin
            wbEn_o <= done && exMem.valid && exMem.ctrl.regWrite;
        end
    end

    always_ff @(posedge clk_i) begin
        if (done) begin
            wbAddr_o <= exMem.destReg;
            wbData_o <= exMem.ctrl.memRead ? loadData : exMem.aluResult;
        end
    end

endmodule

`default_nettype wire

//--- source/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import pipeCtrlPkg::*;
#(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  wire         clk_i,
    input  wire         arstN_i,
    output logic [31:0] imemAddr_o,
    input  wire  [31:0] imemRdata_i,
    output logic        dmemReq_o,
    output logic        dmemWe_o,
    output logic [31:0] dmemAddr_o,
    output logic [31:0] dmemWdata_o,
    input  wire         dmemAck_i,
    input  wire  [31:0] dmemRdata_i,
    output logic        wbEn_o,
    output logic [4:0]  wbAddr_o,
    output logic [31:0] wbData_o
);

    // IF/ID
    logic [31:0] instrD, pcPlus4D;
    logic        validD;
    // ID/EX
    ctrlT        ctrlE;
    logic [31:0] rsValE, rtValE, immE, pcPlus4E;
    logic [4:0]  shamtE, rsE, rtE, destE, rsD, rtD;
    logic        validE;
    // redirects and hazard control
    logic        jumpTaken, branchTaken;
    logic [31:0] jumpTarget, branchTarget;
    logic        stallFD, flushD, flushE, memBusy;
    fwdSelE      fwdA, fwdB;

    exMemIf exMemBus ();

    fetchStage #(.resetPc(resetPc)) fetchStage_i (
        .clk_i(clk_i), .arstN_i(arstN_i),
        .stall_i(stallFD), .flush_i(flushD),
        .jumpTaken_i(jumpTaken), .jumpTarget_i(jumpTarget),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .imemAddr_o(imemAddr_o), .imemRdata_i(imemRdata_i),
        .instrD_o(instrD), .pcPlus4D_o(pcPlus4D), .validD_o(validD)
    );

    decodeStage decodeStage_i (
        .clk_i(clk_i), .arstN_i(arstN_i),
        .instrD_i(instrD), .pcPlus4D_i(pcPlus4D), .validD_i(validD),
        .stall_i(memBusy), .flush_i(flushE),     // whole pipe holds on memory
        .wbEn_i(wbEn_o), .wbAddr_i(wbAddr_o), .wbData_i(wbData_o),
        .rsD_o(rsD), .rtD_o(rtD),
        .jumpTaken_o(jumpTaken), .jumpTarget_o(jumpTarget),
        .ctrlE_o(ctrlE), .rsValE_o(rsValE), .rtValE_o(rtValE), .immE_o(immE),
        .shamtE_o(shamtE), .rsE_o(rsE), .rtE_o(rtE), .destE_o(destE),
        .pcPlus4E_o(pcPlus4E), .validE_o(validE)
    );

    executeStage executeStage_i (
        .clk_i(clk_i), .arstN_i(arstN_i), .stall_i(memBusy),
        .ctrlE_i(ctrlE), .rsValE_i(rsValE), .rtValE_i(rtValE), .immE_i(immE),
        .shamtE_i(shamtE), .destE_i(destE), .pcPlus4E_i(pcPlus4E), .validE_i(validE),
        .fwdA_i(fwdA), .fwdB_i(fwdB), .wbData_i(wbData_o),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget),
        .exMem(exMemBus)
    );

    memStage memStage_i (
        .clk_i(clk_i), .arstN_i(arstN_i), .exMem(exMemBus),
        .dmemReq_o(dmemReq_o), .dmemWe_o(dmemWe_o),
        .dmemAddr_o(dmemAddr_o), .dmemWdata_o(dmemWdata_o),
        .dmemAck_i(dmemAck_i), .dmemRdata_i(dmemRdata_i),
        .memBusy_o(memBusy),
        .wbEn_o(wbEn_o), .wbAddr_o(wbAddr_o), .wbData_o(wbData_o)
    );

    hazardUnit hazardUnit_i (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
        .destE_i(destE), .loadE_i(ctrlE.memRead), .regWriteE_i(ctrlE.regWrite),
        .destM_i(exMemBus.destReg), .regWriteM_i(exMemBus.ctrl.regWrite),
        .wbAddr_i(wbAddr_o), .wbEn_i(wbEn_o),
        .branchTaken_i(branchTaken), .jumpTaken_i(jumpTaken), .memBusy_i(memBusy),
        .stallFD_o(stallFD), .flushD_o(flushD), .flushE_o(flushE),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

endmodule

`default_nettype wire

//--- source/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,    // signed compare
        ALU_SLL     // shifts the second operand by shamt
    } aluOpE;

endpackage

`default_nettype wire

//--- source/pipeCtrlPkg.sv
`default_nettype none

package pipeCtrlPkg;

    import mipsIsaPkg::*;

    // travels with each instruction from decode to writeback
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;   // sign-extended immediate replaces rt
        logic  branchEq;
        logic  branchNe;
        aluOpE aluOp;
    } ctrlT;

    typedef enum logic [1:0] {
        FWD_REGFILE  = 2'd0,
        FWD_FROM_MEM = 2'd1,
        FWD_FROM_WB  = 2'd2
    } fwdSelE;

endpackage

`default_nettype wire

//--- tb/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;

    localparam int quietCycles = 20;    // halt loop watched for stray writes
    localparam logic [31:0] resetPc = 32'h0000_0000;

    logic        clk;
    logic        arstN;
    logic [31:0] imemAddr;
    logic [31:0] imemRdata;
    logic        dmemReq;
    logic        dmemWe;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic        dmemAck;
    logic [31:0] dmemRdata;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    int          expTest [64];
    logic [4:0]  expAddr [64];
    logic [31:0] expData [64];

    int progLen = 0;
    int expCount = 0;
    int expIdx = 0;
    int errorCount = 0;
    int checkCount = 0;
    int cycles = 0;
    int cycleLimit = 0;
    int testWrites = 0;
    int testErrBase = 0;
    int extraWrites = 0;
    int assertFails = 0;
    logic [31:0] rngState = 32'h8e88_9716;
    logic [1:0]  memPhase;     // 0 idle, 1 latency, 2 ack up, 3 release delay
    logic [1:0]  memWait;

    mipsCore #(.resetPc(resetPc)) mipsCore_i (
        .clk_i(clk), .arstN_i(arstN),
        .imemAddr_o(imemAddr), .imemRdata_i(imemRdata),
        .dmemReq_o(dmemReq), .dmemWe_o(dmemWe),
        .dmemAddr_o(dmemAddr), .dmemWdata_o(dmemWdata),
        .dmemAck_i(dmemAck), .dmemRdata_i(dmemRdata),
        .wbEn_o(wbEn), .wbAddr_o(wbAddr), .wbData_o(wbData)
    );

    // combinational instruction fetch with nop beyond the array
    assign imemRdata = (imemAddr[31:8] == 24'd0) ? imem[imemAddr[7:2]] : 32'd0;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (arstN) begin
            cycles <= cycles + 1;
        end
    end

    function automatic logic [1:0] nextDelay();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState[17:16];
    endfunction

    function automatic string testName(input int id);
        case (id)
            1:       return "alu ops";
            2:       return "forwarding";
            3:       return "memory";
            4:       return "taken branches";
            5:       return "fall-through and jump";
            default: return "ordering";
        endcase
    endfunction

    task automatic checkValue(input string sigName, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, sigName, got, exp);
        end
    endtask

    task automatic loadTestData();
        integer     fd;
        integer     cnt;
        integer     ch;
        logic [7:0] tag;
        logic [31:0] word;
        int         tst;
        int         regNum;
        fd = $fopen("tb/mipsCore_testdata.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("ERROR: cannot open tb/mipsCore_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                cnt = $fscanf(fd, " %c", tag);
                if (cnt == 1 && tag == "P") begin
                    cnt = $fscanf(fd, "%h", word);
                    imem[progLen] = word;
                    progLen++;
                end else if (cnt == 1 && tag == "E") begin
                    cnt = $fscanf(fd, "%d %d %h", tst, regNum, word);
                    expTest[expCount] = tst;
                    expAddr[expCount] = regNum[4:0];
                    expData[expCount] = word;
                    expCount++;
                end else if (cnt == 1) begin
                    ch = $fgetc(fd);     // skip a comment line
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // four-phase data memory slave with random latencies
    always @(posedge clk) begin
        if (!arstN) begin
            memPhase <= 2'd0;
            dmemAck  <= 1'b0;
        end else begin
            case (memPhase)
                2'd0: begin
                    if (dmemReq) begin
                        memWait  <= nextDelay();
                        memPhase <= 2'd1;
                    end
                end
                2'd1: begin
                    if (memWait != 2'd0) begin
                        memWait <= memWait - 2'd1;
                    end else begin
                        if (dmemAddr[31:8] != 24'd0 || dmemAddr[1:0] != 2'b00) begin
                            errorCount++;
                            $display("ERROR: data access at %h is outside the 64-word memory",
                                     dmemAddr);
                        end else if (dmemWe) begin
                            dmem[dmemAddr[7:2]] <= dmemWdata;
                        end else begin
                            dmemRdata <= dmem[dmemAddr[7:2]];
                        end
                        dmemAck  <= 1'b1;
                        memPhase <= 2'd2;
                    end
                end
                2'd2: begin
                    if (!dmemReq) begin
                        memWait  <= nextDelay();
                        memPhase <= 2'd3;
                    end
                end
                default: begin
                    if (memWait != 2'd0) begin
                        memWait <= memWait - 2'd1;
                    end else begin
                        dmemAck  <= 1'b0;
                        memPhase <= 2'd0;
                    end
                end
            endcase
        end
    end

    // writeback monitor samples on the falling edge
    always @(negedge clk) begin
        if (arstN && wbEn) begin
            if (expIdx < expCount) begin
                checkValue("wbAddr_o", {27'd0, wbAddr}, {27'd0, expAddr[expIdx]});
                checkValue("wbData_o", wbData, expData[expIdx]);
                testWrites++;
                expIdx++;
                if (expIdx == expCount || expTest[expIdx] != expTest[expIdx - 1]) begin
                    $display("test %0d %s: %0d writebacks, %0d errors", expTest[expIdx - 1],
                             testName(expTest[expIdx - 1]), testWrites,
                             errorCount - testErrBase);
                    testWrites  = 0;
                    testErrBase = errorCount;
                end
            end else begin
                extraWrites++;
                errorCount++;
                $display("ERROR: unexpected writeback r%0d = %h after the last expected one",
                         wbAddr, wbData);
            end
        end
    end

    initial begin
        arstN     <= 1'b0;
        dmemAck   <= 1'b0;
        dmemRdata <= 32'd0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'd0;
            dmem[i] = 32'd0;
        end
        loadTestData();
        cycleLimit = (progLen + expCount) * 8;
        repeat (9) @(posedge clk);
        @(negedge clk);
        checkValue("imemAddr_o", imemAddr, resetPc);
        checkValue("dmemReq_o", {31'd0, dmemReq}, 32'd0);
        checkValue("wbEn_o", {31'd0, wbEn}, 32'd0);
        $display("reset state: %0d errors", errorCount - testErrBase);
        testErrBase = errorCount;
        @(posedge clk);
        arstN <= 1'b1;
        if (expCount == 0) begin
            errorCount++;
            $display("ERROR: no expected writebacks were loaded");
        end else begin
            while (expIdx < expCount && cycles < cycleLimit) begin
                @(posedge clk);
            end
            if (expIdx < expCount) begin
                errorCount++;
                $display("ERROR: timeout after %0d cycles, only %0d of %0d writebacks seen",
                         cycles, expIdx, expCount);
            end else begin
                repeat (quietCycles) @(posedge clk);
                $display("test 6 %s: %0d writebacks in order, %0d extra", testName(6),
                         expIdx, extraWrites);
            end
        end
        assertFails = mipsCore_i.memStage_i.memAsserts_i.failCount;
        if (assertFails != 0) begin
            errorCount += assertFails;
            $display("ERROR: %0d assertion failures on the memory stage", assertFails);
        end
        $display("summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mipsCore_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAsserts (
    input wire        clk_i,
    input wire        arstN_i,
    input wire        dmemReq_i,
    input wire        dmemAck_i,
    input wire        dmemWe_i,
    input wire [31:0] dmemAddr_i,
    input wire [31:0] dmemWdata_i,
    input wire        wbEn_i,
    input wire [4:0]  wbAddr_i
);

    int failCount = 0;     // assertion failures so far

    // req waits for the memory in phase 1
    reqHeld: assert property (@(posedge clk_i) disable iff (!arstN_i)
        dmemReq_i && !dmemAck_i |=> dmemReq_i)
        else begin
            failCount++;
            $error("dmemReq_o dropped before dmemAck_i arrived");
        end

    reqStable: assert property (@(posedge clk_i) disable iff (!arstN_i)
        $past(dmemReq_i) && dmemReq_i |->
            $stable(dmemAddr_i) && $stable(dmemWdata_i) && $stable(dmemWe_i))
        else begin
            failCount++;
            $error("address, data or write flag moved while dmemReq_o was high");
        end

    // a new request only after the previous ack is gone
    reqAfterRelease: assert property (@(posedge clk_i) disable iff (!arstN_i)
        $rose(dmemReq_i) |-> !dmemAck_i)
        else begin
            failCount++;
            $error("dmemReq_o rose while dmemAck_i was still high");
        end

    noZeroWrite: assert property (@(posedge clk_i) disable iff (!arstN_i)
        wbEn_i |-> wbAddr_i != 5'd0)
        else begin
            failCount++;
            $error("writeback to register 0");
        end

endmodule

bind memStage mipsCoreAsserts memAsserts_i (
    .clk_i(clk_i),
    .arstN_i(arstN_i),
    .dmemReq_i(dmemReq_o),
    .dmemAck_i(dmemAck_i),
    .dmemWe_i(dmemWe_o),
    .dmemAddr_i(dmemAddr_o),
    .dmemWdata_i(dmemWdata_o),
    .wbEn_i(wbEn_o),
    .wbAddr_i(wbAddr_o)
);

`default_nettype wire

//--- tb/mipsCore_testdata.txt
# P <instruction word, hex>                  program, loaded from address 0 upward
# E <test> <register, decimal> <value, hex>  expected writebacks in program order
# test 1: alu ops
P 240100F0
P 2402FF3C
P 00221821
P 00222023
P 00222824
P 00223025
P 0022382A
P 0041402A
P 00014900
P 252AFFFF
E 1 1 000000F0
E 1 2 FFFFFF3C
E 1 3 0000002C
E 1 4 000001B4
E 1 5 00000030
E 1 6 FFFFFFFC
E 1 7 00000000
E 1 8 00000001
E 1 9 00000F00
E 1 10 00000EFF
# test 2: forwarding from mem and wb, youngest producer wins
P 240B0007
P 016B6021
P 018B6821
P 01AC7023
P 01CD7825
P 24100001
P 26100002
P 02108821
E 2 11 00000007
E 2 12 0000000E
E 2 13 00000015
E 2 14 00000007
E 2 15 00000017
E 2 16 00000001
E 2 16 00000003
E 2 17 00000006
# test 3: store, load back, load-use into alu and into store
P 24120040
P AE510000
P AE4F0004
P 8E530000
P 0273A021
P 8E550004
P AE550008
P 8E560008
P 26D70001
E 3 18 00000040
E 3 19 00000006
E 3 20 0000000C
E 3 21 00000017
E 3 22 00000017
E 3 23 00000018
# test 4: taken beq and bne, the 0xBAD writes must never show
P 12710002
P 24180BAD
P 24190BAD
P 24180011
P 17000002
P 24190BAD
P 24190BAD
P 27190022
E 4 24 00000011
E 4 25 00000033
# test 5: not-taken beq and bne, then j over one instruction, then halt loop
P 13190001
P 241A0055
P 175A0001
P 275B0001
P 08000029
P 241C0BAD
P 277C0010
P 0800002A
E 5 26 00000055
E 5 27 00000056
E 5 28 00000066
